// ==== aes_core.f ====
logic/aes_pkg.sv
logic/sbox_word.sv
logic/key_expand_stage.sv
logic/round_stage.sv
logic/final_round_stage.sv
logic/aes_core.sv
tb/aes_checker.sv
tb/aes_core_asserts.sv
tb/aes_core_tb.sv

// ==== logic/aes_core.sv ====
`timescale 1ns/1ps

module aes_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  aes_block_t state,
    input  aes_block_t key,
    output aes_block_t out
);

    aes_block_t state_r;
    aes_block_t key_r;

    // Index i holds the state and key that enter round i
    aes_block_t state_chain [NUM_ROUNDS];
    aes_block_t key_chain   [NUM_ROUNDS];
    aes_block_t round_keys  [NUM_ROUNDS];

    ////////////////////////////////////////////////////////////
    // Input whitening
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        state_r <= state ^ key;
        key_r   <= key;
    end

    assign state_chain[0] = state_r;
    assign key_chain[0]   = key_r;

    ////////////////////////////////////////////////////////////
    // Key schedule, two cycles per step
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_ROUNDS; i++) begin : g_key
        if (i < NUM_ROUNDS - 1) begin : g_mid
            key_expand_stage #(
                .ROUND_CONST (RCON[i])
            ) u_key (
                .clk       (clk),
                .key_in    (key_chain[i]),
                .round_key (round_keys[i]),
                .next_key  (key_chain[i+1])
            );
        end else begin : g_last
            // Nothing follows the last step
            key_expand_stage #(
                .ROUND_CONST (RCON[i])
            ) u_key (
                .clk       (clk),
                .key_in    (key_chain[i]),
                .round_key (round_keys[i]),
                .next_key  ()
            );
        end
    end

    ////////////////////////////////////////////////////////////
    // Rounds
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_ROUNDS - 1; i++) begin : g_round
        round_stage u_round (
            .clk       (clk),
            .state_in  (state_chain[i]),
            .round_key (round_keys[i]),
            .state_out (state_chain[i+1])
        );
    end

    final_round_stage u_final (
        .clk       (clk),
        .state_in  (state_chain[NUM_ROUNDS-1]),
        .round_key (round_keys[NUM_ROUNDS-1]),
        .state_out (out)
    );

endmodule

// ==== logic/aes_pkg.sv ====
package aes_pkg;

    localparam int BLOCK_W      = 128;
    localparam int WORD_W       = 32;
    localparam int BYTE_W       = 8;
    localparam int NUM_COLS     = BLOCK_W / WORD_W;
    localparam int NUM_ROWS     = WORD_W / BYTE_W;
    localparam int NUM_ROUNDS   = 10;

    // Whitening register plus two cycles per round
    localparam int CORE_LATENCY = 1 + 2 * NUM_ROUNDS;

    // Column 0 and byte 0 of the state block sit in the top bits
    typedef union packed {
        logic [0:NUM_COLS-1][WORD_W-1:0]            col;
        logic [0:NUM_COLS*NUM_ROWS-1][BYTE_W-1:0]   bytes;
    } aes_block_t;

    ////////////////////////////////////////////////////////////
    // Substitution table with entry 0 first
    ////////////////////////////////////////////////////////////

    localparam logic [0:255][BYTE_W-1:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // Round constants for the ten key-schedule steps
    localparam logic [0:NUM_ROUNDS-1][BYTE_W-1:0] RCON = {
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    ////////////////////////////////////////////////////////////
    // GF(2^8) helpers
    ////////////////////////////////////////////////////////////

    // Multiply by x and reduce by the AES polynomial
    function automatic logic [BYTE_W-1:0] gf_double(input logic [BYTE_W-1:0] b);
        logic [BYTE_W-1:0] shifted;
        shifted = {b[BYTE_W-2:0], 1'b0};
        if (b[BYTE_W-1]) begin
            return shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

endpackage

// ==== logic/final_round_stage.sv ====
`timescale 1ns/1ps

module final_round_stage
    import aes_pkg::*;
(
    input  logic       clk,
    input  aes_block_t state_in,
    input  aes_block_t round_key,
    output aes_block_t state_out
);

    aes_block_t sub;
    aes_block_t shifted;

    // SubBytes per column
    for (genvar c = 0; c < NUM_COLS; c++) begin : g_sub
        sbox_word u_sbox (
            .clk      (clk),
            .word_in  (state_in.col[c]),
            .word_out (sub.col[c])
        );
    end

    // ShiftRows takes row r of column j from column j+r
    always_comb begin
        for (int j = 0; j < NUM_COLS; j++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                shifted.bytes[NUM_ROWS*j + r] =
                    sub.bytes[NUM_ROWS*((j + r) % NUM_COLS) + r];
            end
        end
    end

    // No MixColumns in the last round
    always_ff @(posedge clk) begin
        state_out <= shifted ^ round_key;
    end

endmodule

// ==== logic/key_expand_stage.sv ====
`timescale 1ns/1ps

module key_expand_stage
    import aes_pkg::*;
#(
    parameter logic [BYTE_W-1:0] ROUND_CONST = 8'h01
) (
    input  logic       clk,
    input  aes_block_t key_in,
    output aes_block_t round_key,
    output aes_block_t next_key
);

    aes_block_t        xor_next;
    aes_block_t        xor_r;
    logic [WORD_W-1:0] rot_word;
    logic [WORD_W-1:0] sub_word;

    // Running XOR of the columns with rcon folded into the first one
    always_comb begin
        logic [WORD_W-1:0] run;
        run = key_in.col[0] ^ {ROUND_CONST, {(WORD_W-BYTE_W){1'b0}}};
        xor_next.col[0] = run;
        for (int c = 1; c < NUM_COLS; c++) begin
            run = run ^ key_in.col[c];
            xor_next.col[c] = run;
        end
    end

    always_ff @(posedge clk) begin
        xor_r <= xor_next;
    end

    // RotWord on the last column feeds the registered SubWord
    assign rot_word = {key_in.col[NUM_COLS-1][WORD_W-BYTE_W-1:0],
                       key_in.col[NUM_COLS-1][WORD_W-1:WORD_W-BYTE_W]};

    sbox_word u_sbox (
        .clk      (clk),
        .word_in  (rot_word),
        .word_out (sub_word)
    );

    // Substituted word lands in every column
    assign round_key = xor_r ^ {NUM_COLS{sub_word}};

    always_ff @(posedge clk) begin
        next_key <= round_key;
    end

endmodule

// ==== logic/round_stage.sv ====
`timescale 1ns/1ps

module round_stage
    import aes_pkg::*;
(
    input  logic       clk,
    input  aes_block_t state_in,
    input  aes_block_t round_key,
    output aes_block_t state_out
);

    aes_block_t sb_r;
    aes_block_t mixed;

    ////////////////////////////////////////////////////////////
    // SubBytes in the first cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_COLS * NUM_ROWS; i++) begin
            sb_r.bytes[i] <= SBOX[state_in.bytes[i]];
        end
    end

    ////////////////////////////////////////////////////////////
    // ShiftRows, MixColumns and AddRoundKey
    ////////////////////////////////////////////////////////////

    // Each byte yields the MixColumns vector {2s, s, s, 3s} rotated by
    // its row, and lands in the column that ShiftRows moves it to
    always_comb begin
        aes_block_t          acc;
        logic [BYTE_W-1:0]   s1;
        logic [BYTE_W-1:0]   s2;
        logic [BYTE_W-1:0]   s3;
        logic [2*WORD_W-1:0] t_pair;
        acc = round_key;
        for (int c = 0; c < NUM_COLS; c++) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                s1 = sb_r.bytes[NUM_ROWS*c + r];
                s2 = gf_double(s1);
                s3 = s2 ^ s1;
                // Rotate right by r bytes
                t_pair = {2{s2, s1, s1, s3}} >> (BYTE_W * r);
                acc.col[(c - r + NUM_COLS) % NUM_COLS] ^= t_pair[WORD_W-1:0];
            end
        end
        mixed = acc;
    end

    // Second cycle
    always_ff @(posedge clk) begin
        state_out <= mixed;
    end

endmodule

// ==== logic/sbox_word.sv ====
`timescale 1ns/1ps

module sbox_word
    import aes_pkg::*;
(
    input  logic              clk,
    input  logic [WORD_W-1:0] word_in,
    output logic [WORD_W-1:0] word_out
);

    // One registered table lookup per byte
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ROWS; i++) begin
            word_out[i*BYTE_W +: BYTE_W] <= SBOX[word_in[i*BYTE_W +: BYTE_W]];
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the AES core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module aes_core_tb -Mdir obj_dir -f aes_core.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vaes_core_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints its verdict on a line of its own
if grep -q "^Everything OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// ==== tb/aes_checker.sv ====
`timescale 1ns/1ps

module aes_checker
    import aes_pkg::*;
(
    input  logic               clk,
    input  logic [BLOCK_W-1:0] out,
    input  logic               exp_valid,
    input  logic [BLOCK_W-1:0] exp_out,
    input  int                 exp_tag,
    output int                 pass_count,
    output int                 fail_count
);

    // One register per cycle of core latency
    localparam int DEPTH = CORE_LATENCY;

    logic [BLOCK_W-1:0] exp_pipe   [DEPTH];
    logic               valid_pipe [DEPTH];
    int                 tag_pipe   [DEPTH];
    int                 check_num;

    initial begin
        pass_count = 0;
        fail_count = 0;
        check_num  = 0;
        for (int i = 0; i < DEPTH; i++) begin
            valid_pipe[i] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Expected values ride alongside the blocks in the core
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        valid_pipe[0] <= exp_valid;
        exp_pipe[0]   <= exp_out;
        tag_pipe[0]   <= exp_tag;
        for (int i = 1; i < DEPTH; i++) begin
            valid_pipe[i] <= valid_pipe[i-1];
            exp_pipe[i]   <= exp_pipe[i-1];
            tag_pipe[i]   <= tag_pipe[i-1];
        end

        // Compare the registered output against the oldest entry
        if (valid_pipe[DEPTH-1]) begin
            if (out === exp_pipe[DEPTH-1]) begin
                $display("test %0d vector %0d: out %h as expected",
                         check_num, tag_pipe[DEPTH-1], out);
                pass_count <= pass_count + 1;
            end else begin
                $display("ERR out expected %h got %h (test %0d vector %0d)",
                         exp_pipe[DEPTH-1], out, check_num, tag_pipe[DEPTH-1]);
                fail_count <= fail_count + 1;
            end
            check_num <= check_num + 1;
        end
    end

endmodule

// ==== tb/aes_core_asserts.sv ====
`timescale 1ns/1ps

module aes_core_asserts
    import aes_pkg::*;
(
    input logic       clk,
    input aes_block_t state,
    input aes_block_t key,
    input aes_block_t out
);

    logic                 primed = 1'b0;
    logic [2*BLOCK_W-1:0] prev_in;
    int                   defined_cnt = 0;
    int                   stable_cnt = 0;
    int                   assert_fails = 0;

    // Edges with known inputs, and edges with inputs unchanged
    always @(posedge clk) begin
        primed  <= 1'b1;
        prev_in <= {state, key};
        if ($isunknown({state, key})) begin
            defined_cnt <= 0;
        end else if (defined_cnt <= CORE_LATENCY) begin
            defined_cnt <= defined_cnt + 1;
        end
        if (!primed || $isunknown({state, key}) || {state, key} != prev_in) begin
            stable_cnt <= 0;
        end else if (stable_cnt <= CORE_LATENCY) begin
            stable_cnt <= stable_cnt + 1;
        end
    end

    out_known: assert property (@(posedge clk)
        defined_cnt > CORE_LATENCY |-> !$isunknown(out))
        else begin
            $error("out is unknown after %0d cycles of defined inputs", defined_cnt);
            assert_fails++;
        end

    out_steady: assert property (@(posedge clk)
        stable_cnt > CORE_LATENCY |-> $stable(out))
        else begin
            $error("out changed although the inputs were held for %0d cycles", stable_cnt);
            assert_fails++;
        end

endmodule

bind aes_core aes_core_asserts u_asserts (
    .clk   (clk),
    .state (state),
    .key   (key),
    .out   (out)
);

// ==== tb/aes_core_tb.sv ====
`timescale 1ns/1ps

module aes_core_tb
    import aes_pkg::*;
();

    localparam int HOLD_CYCLES = 30;

    logic               clk;
    logic               rst;
    aes_block_t         state;
    aes_block_t         key;
    aes_block_t         out;

    // Expected ciphertext handed to the checker with each block
    logic               exp_valid;
    logic [BLOCK_W-1:0] exp_out;
    int                 exp_tag;
    int                 pass_count;
    int                 fail_count;

    logic [BLOCK_W-1:0] vec_key [$];
    logic [BLOCK_W-1:0] vec_pt  [$];
    logic [BLOCK_W-1:0] vec_ct  [$];
    int                 issued;
    logic               timed_out;

    aes_core UUT (
        .clk   (clk),
        .state (state),
        .key   (key),
        .out   (out)
    );

    aes_checker u_checker (
        .clk        (clk),
        .out        (out),
        .exp_valid  (exp_valid),
        .exp_out    (exp_out),
        .exp_tag    (exp_tag),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int                 fd;
        string              line;
        logic [BLOCK_W-1:0] k;
        logic [BLOCK_W-1:0] p;
        logic [BLOCK_W-1:0] c;
        fd = $fopen("tb/aes_tests.hex", "r");
        if (fd == 0) begin
            $display("Cannot open tb/aes_tests.hex for reading");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines scan no fields
            if ($sscanf(line, "%h %h %h", k, p, c) == 3) begin
                vec_key.push_back(k);
                vec_pt.push_back(p);
                vec_ct.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input int idx);
        @(posedge clk);
        state     <= vec_pt[idx];
        key       <= vec_key[idx];
        exp_out   <= vec_ct[idx];
        exp_valid <= 1'b1;
        exp_tag   <= idx;
        issued++;
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        state     <= '0;
        key       <= '0;
        exp_valid <= 1'b0;
    endtask

    // Wait until every issued block has been checked
    task automatic wait_for_checks(input int in_flight);
        int limit;
        int waited;
        limit  = in_flight + CORE_LATENCY + 20;
        waited = 0;
        while (!timed_out && pass_count + fail_count < issued) begin
            @(posedge clk);
            waited++;
            if (waited >= limit && pass_count + fail_count < issued) begin
                $display("Timeout: only %0d of %0d checks done after %0d cycles",
                         pass_count + fail_count, issued, waited);
                timed_out = 1'b1;
            end
        end
    endtask

    // A vector whose key differs from both neighbours in the sequence
    function automatic int pick_partner(input int idx);
        int n;
        int cand;
        int follow;
        n      = vec_key.size();
        follow = (idx + 1) % n;
        for (int k = 1; k < n; k++) begin
            cand = (idx + k) % n;
            if (vec_key[cand] != vec_key[idx] && vec_key[cand] != vec_key[follow]) begin
                return cand;
            end
        end
        return -1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int n;
        int partner;
        int phase_start;
        state     = '0;
        key       = '0;
        exp_out   = '0;
        exp_valid = 1'b0;
        exp_tag   = 0;
        issued    = 0;
        timed_out = 1'b0;
        rst       = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        load_vectors();
        n = vec_key.size();
        $display("Loaded %0d vectors", n);
        if (n > 0) begin
            $display("Phase 1: each vector alone, then idle");
            for (int i = 0; i < n && !timed_out; i++) begin
                apply_vector(i);
                idle_inputs();
                wait_for_checks(1);
            end

            $display("Phase 2: all vectors back to back");
            phase_start = issued;
            for (int i = 0; i < n && !timed_out; i++) begin
                apply_vector(i);
            end
            idle_inputs();
            wait_for_checks(issued - phase_start);

            $display("Phase 3: key changes on every cycle");
            phase_start = issued;
            for (int i = 0; i < n && !timed_out; i++) begin
                partner = pick_partner(i);
                apply_vector(i);
                if (partner >= 0) begin
                    apply_vector(partner);
                end
            end
            idle_inputs();
            wait_for_checks(issued - phase_start);

            $display("Phase 4: one vector held for %0d cycles", HOLD_CYCLES);
            phase_start = issued;
            for (int i = 0; i < HOLD_CYCLES && !timed_out; i++) begin
                apply_vector(0);
            end
            idle_inputs();
            wait_for_checks(issued - phase_start);
        end else begin
            $display("No test vectors were read from tb/aes_tests.hex");
        end

        $display("Checks: %0d passed, %0d failed, %0d assertion failures",
                 pass_count, fail_count, UUT.u_asserts.assert_fails);
        if (n > 0 && !timed_out && fail_count == 0 && pass_count == issued
                && UUT.u_asserts.assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== tb/aes_tests.hex ====
// Each line holds key then plaintext then expected ciphertext
// as three 128-bit hex words separated by spaces

// FIPS-197 appendix C.1
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a

// FIPS-197 appendix B
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32

// SP 800-38A F.1.1 ECB-AES128 blocks 1 to 4
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4

// All-zero key and plaintext
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
